// ==== src/gamePkg.sv ====
package gamePkg;

    // one press from the keyboard front end
    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } KeyEvent;

    // one-hot screen levels
    typedef struct packed {
        logic intro;
        logic map;
        logic battle;
    } ScreenSel;

    // player tile on the map
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } MapPos;

    typedef struct packed {
        logic [7:0] playerHp;
        logic [7:0] bossHp;
    } BattleStatus;

    // keyboard usage codes
    localparam logic [7:0] KeySpace  = 8'h2C;
    localparam logic [7:0] KeyEscape = 8'h29;
    // B shortcut straight into battle
    localparam logic [7:0] KeyBattle = 8'h05;
    localparam logic [7:0] KeyAttack = 8'h04;
    localparam logic [7:0] KeyRight  = 8'h4F;
    localparam logic [7:0] KeyLeft   = 8'h50;
    localparam logic [7:0] KeyDown   = 8'h51;
    localparam logic [7:0] KeyUp     = 8'h52;

    // building door and spawn point
    localparam logic [3:0] DoorX  = 4'd12;
    localparam logic [3:0] DoorY  = 4'd3;
    localparam logic [3:0] StartX = 4'd1;
    localparam logic [3:0] StartY = 4'd1;

    // damage per hit
    localparam logic [7:0] AttackDamage = 8'd10;
    localparam logic [7:0] BossDamage   = 8'd7;

endpackage

// ==== src/keyDecoder.sv ====
`timescale 1ns/1ps

module keyDecoder (
    input  logic              Clk,
    input  logic              rstN,
    input  logic [7:0]        keycode,
    output gamePkg::KeyEvent  keyEvt
);

    // sampled keycode and the sample before it
    logic [7:0] keyReg;
    logic [7:0] prevKey;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            keyReg  <= 8'h00;
            prevKey <= 8'h00;
        end
        else
        begin
            keyReg  <= keycode;
            prevKey <= keyReg;
        end
    end

    // press strobe only on a change to a non-zero code
    always_comb
    begin
        keyEvt.code  = keyReg;
        keyEvt.valid = (keyReg != 8'h00) && (keyReg != prevKey);
    end

    // a press never carries the idle code
    assert property (@(posedge Clk) disable iff (!rstN)
        keyEvt.valid |-> keyEvt.code != 8'h00)
        else $error("keyDecoder: event with zero code");

endmodule

// ==== src/screenFsm.sv ====
`timescale 1ns/1ps

module screenFsm (
    input  logic              Clk,
    input  logic              rstN,
    input  gamePkg::KeyEvent  keyEvt,
    input  logic              enterBuilding,
    input  logic              playerDied,
    input  logic              bossDied,
    output gamePkg::ScreenSel screen
);

    typedef enum logic [1:0] {
        IntroScreen,
        MapScreen,
        BattleScreen
    } ScreenState;

    ScreenState state;
    ScreenState nextState;

    logic spacePressed;
    logic battlePressed;
    logic escapePressed;

    assign spacePressed  = keyEvt.valid && (keyEvt.code == gamePkg::KeySpace);
    assign battlePressed = keyEvt.valid && (keyEvt.code == gamePkg::KeyBattle);
    assign escapePressed = keyEvt.valid && (keyEvt.code == gamePkg::KeyEscape);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            state <= IntroScreen;
        else
            state <= nextState;
    end

    always_comb
    begin
        // stay put unless something legal for this screen happens
        nextState = state;
        case (state)
            IntroScreen:
            begin
                if (spacePressed)
                    nextState = MapScreen;
            end
            MapScreen:
            begin
                if (battlePressed || enterBuilding)
                    nextState = BattleScreen;
            end
            BattleScreen:
            begin
                // escape wins over a death in the same cycle
                if (escapePressed)
                    nextState = MapScreen;
                else if (playerDied)
                    nextState = IntroScreen;
                else if (bossDied)
                    nextState = IntroScreen;
            end
            default:
            begin
                nextState = IntroScreen;
            end
        endcase
    end

    // screen levels straight from the state
    always_comb
    begin
        screen = '0;
        case (state)
            IntroScreen:  screen.intro  = 1'b1;
            MapScreen:    screen.map    = 1'b1;
            BattleScreen: screen.battle = 1'b1;
            default:      screen.intro  = 1'b1;
        endcase
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        $onehot(screen))
        else $error("screenFsm: screen select not one-hot");

endmodule

// ==== src/mapWalker.sv ====
`timescale 1ns/1ps

module mapWalker #(
    parameter int MapSize = 16
) (
    input  logic              Clk,
    input  logic              rstN,
    input  gamePkg::KeyEvent  keyEvt,
    input  gamePkg::ScreenSel screen,
    output gamePkg::MapPos    pos,
    output logic              enterBuilding
);

    // last tile on each axis
    localparam logic [3:0] MaxCoord = 4'(MapSize - 1);

    gamePkg::MapPos nextPos;

    // one tile per arrow press, held at the map edges
    always_comb
    begin
        nextPos = pos;
        if (keyEvt.valid)
        begin
            case (keyEvt.code)
                gamePkg::KeyRight:
                begin
                    if (pos.x != MaxCoord)
                        nextPos.x = pos.x + 4'd1;
                end
                gamePkg::KeyLeft:
                begin
                    if (pos.x != 4'd0)
                        nextPos.x = pos.x - 4'd1;
                end
                // y grows downwards
                gamePkg::KeyDown:
                begin
                    if (pos.y != MaxCoord)
                        nextPos.y = pos.y + 4'd1;
                end
                gamePkg::KeyUp:
                begin
                    if (pos.y != 4'd0)
                        nextPos.y = pos.y - 4'd1;
                end
                default:
                begin
                    nextPos = pos;
                end
            endcase
        end
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pos.x <= gamePkg::StartX;
            pos.y <= gamePkg::StartY;
        end
        else if (screen.intro)
        begin
            // back to the spawn point whenever the intro is up
            pos.x <= gamePkg::StartX;
            pos.y <= gamePkg::StartY;
        end
        else if (screen.map)
        begin
            pos <= nextPos;
        end
    end

    // standing on the door while the map is shown
    assign enterBuilding = screen.map
                           && (pos.x == gamePkg::DoorX)
                           && (pos.y == gamePkg::DoorY);

    assert property (@(posedge Clk) disable iff (!rstN)
        (int'(pos.x) < MapSize) && (int'(pos.y) < MapSize))
        else $error("mapWalker: position outside the map");

endmodule

// ==== src/battleEngine.sv ====
`timescale 1ns/1ps

module battleEngine #(
    parameter int PlayerHp   = 40,
    parameter int BossHp     = 50,
    parameter int BossPeriod = 20
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  gamePkg::KeyEvent     keyEvt,
    input  gamePkg::ScreenSel    screen,
    output gamePkg::BattleStatus status,
    output logic                 playerDied,
    output logic                 bossDied
);

    localparam logic [7:0] PlayerHpInit = 8'(PlayerHp);
    localparam logic [7:0] BossHpInit   = 8'(BossHp);
    localparam int         CntW         = (BossPeriod > 1) ? $clog2(BossPeriod) : 1;
    localparam logic [CntW-1:0] StrikeAt = CntW'(BossPeriod - 1);

    logic [CntW-1:0] strikeCnt;
    logic            attackHit;
    logic            bossStrike;
    logic            bossFalls;
    logic            playerFalls;

    assign attackHit  = keyEvt.valid && (keyEvt.code == gamePkg::KeyAttack);
    assign bossStrike = (strikeCnt == StrikeAt);

    // hit that takes the value to zero or below
    assign bossFalls   = (status.bossHp <= gamePkg::AttackDamage);
    assign playerFalls = (status.playerHp <= gamePkg::BossDamage);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            status.playerHp <= PlayerHpInit;
            status.bossHp   <= BossHpInit;
            strikeCnt       <= '0;
            playerDied      <= 1'b0;
            bossDied        <= 1'b0;
        end
        else if (!screen.battle)
        begin
            // fresh fight every time the battle screen comes up
            status.playerHp <= PlayerHpInit;
            status.bossHp   <= BossHpInit;
            strikeCnt       <= '0;
            playerDied      <= 1'b0;
            bossDied        <= 1'b0;
        end
        else
        begin
            strikeCnt  <= bossStrike ? '0 : strikeCnt + 1'b1;
            playerDied <= bossStrike && playerFalls;
            bossDied   <= attackHit && bossFalls;

            if (attackHit)
                status.bossHp <= bossFalls ? 8'd0 : status.bossHp - gamePkg::AttackDamage;

            // boss strike lands independently of the player's attack
            if (bossStrike)
                status.playerHp <= playerFalls ? 8'd0
                                               : status.playerHp - gamePkg::BossDamage;
        end
    end

    assert property (@(posedge Clk) disable iff (!rstN)
        (status.playerHp <= PlayerHpInit) && (status.bossHp <= BossHpInit))
        else $error("battleEngine: health above its start value");

    // pulses are raised by an edge seen during battle
    assert property (@(posedge Clk) disable iff (!rstN)
        (playerDied || bossDied) |-> $past(screen.battle))
        else $error("battleEngine: died pulse outside battle");

endmodule

// ==== src/gameTop.sv ====
`timescale 1ns/1ps

module gameTop #(
    parameter int MapSize    = 16,
    parameter int PlayerHp   = 40,
    parameter int BossHp     = 50,
    parameter int BossPeriod = 20
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic [7:0]           keycode,
    output gamePkg::ScreenSel    screen,
    output gamePkg::MapPos       pos,
    output gamePkg::BattleStatus status
);

    gamePkg::KeyEvent keyEvt;
    logic             enterBuilding;
    logic             playerDied;
    logic             bossDied;

    keyDecoder decoder (
        .Clk     (Clk),
        .rstN    (rstN),
        .keycode (keycode),
        .keyEvt  (keyEvt)
    );

    screenFsm controller (
        .Clk           (Clk),
        .rstN          (rstN),
        .keyEvt        (keyEvt),
        .enterBuilding (enterBuilding),
        .playerDied    (playerDied),
        .bossDied      (bossDied),
        .screen        (screen)
    );

    mapWalker #(
        .MapSize (MapSize)
    ) walker (
        .Clk           (Clk),
        .rstN          (rstN),
        .keyEvt        (keyEvt),
        .screen        (screen),
        .pos           (pos),
        .enterBuilding (enterBuilding)
    );

    battleEngine #(
        .PlayerHp   (PlayerHp),
        .BossHp     (BossHp),
        .BossPeriod (BossPeriod)
    ) battle (
        .Clk        (Clk),
        .rstN       (rstN),
        .keyEvt     (keyEvt),
        .screen     (screen),
        .status     (status),
        .playerDied (playerDied),
        .bossDied   (bossDied)
    );

endmodule

// ==== verif/gameTb.sv ====
`timescale 1ns/1ps

module gameTb;

    localparam int                MapSize      = 16;
    localparam int                BossPeriod   = 12;
    localparam int                RandomCycles = 4000;
    localparam logic [7:0]        PlayerStart  = 8'd40;
    localparam logic [7:0]        BossStart    = 8'd50;
    localparam gamePkg::ScreenSel IntroSel     = 3'b100;
    localparam gamePkg::ScreenSel MapSel       = 3'b010;
    localparam gamePkg::ScreenSel BattleSel    = 3'b001;

    logic                 Clk;
    logic                 rstN;
    logic [7:0]           keycode;
    gamePkg::ScreenSel    screen;
    gamePkg::MapPos       pos;
    gamePkg::BattleStatus status;

    // cycle model state
    logic [7:0]           keyReg;
    logic [7:0]           prevKey;
    gamePkg::ScreenSel    expScreen;
    gamePkg::MapPos       expPos;
    gamePkg::BattleStatus expStatus;
    int                   strikeCnt;
    logic                 playerDied;
    logic                 bossDied;
    int unsigned          seedInit;
    int                   hold;
    logic [7:0]           key;

    gameTop #(
        .BossPeriod (BossPeriod)
    ) uut (
        .Clk     (Clk),
        .rstN    (rstN),
        .keycode (keycode),
        .screen  (screen),
        .pos     (pos),
        .status  (status)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    task automatic resetModel();
        keyReg     = 8'h00;
        prevKey    = 8'h00;
        expScreen  = IntroSel;
        expPos     = {gamePkg::StartX, gamePkg::StartY};
        expStatus  = {PlayerStart, BossStart};
        strikeCnt  = 0;
        playerDied = 1'b0;
        bossDied   = 1'b0;
    endtask

    // one clock edge of the whole subsystem
    task automatic stepModel();
        logic              press;
        logic              door;
        logic              strike;
        int                hp;
        gamePkg::ScreenSel nextScreen;
        press = (keyReg != 8'h00) && (keyReg != prevKey);
        door  = expScreen.map && (expPos == {gamePkg::DoorX, gamePkg::DoorY});
        nextScreen = expScreen;
        if (expScreen.intro && press && keyReg == gamePkg::KeySpace)
            nextScreen = MapSel;
        else if (expScreen.map && ((press && keyReg == gamePkg::KeyBattle) || door))
            nextScreen = BattleSel;
        else if (expScreen.battle && press && keyReg == gamePkg::KeyEscape)
            nextScreen = MapSel;
        else if (expScreen.battle && (playerDied || bossDied))
            nextScreen = IntroSel;
        if (expScreen.intro)
            expPos = {gamePkg::StartX, gamePkg::StartY};
        else if (expScreen.map && press)
        begin
            if (keyReg == gamePkg::KeyRight && int'(expPos.x) < MapSize - 1)
                expPos.x = expPos.x + 4'd1;
            if (keyReg == gamePkg::KeyLeft && expPos.x != 4'd0)
                expPos.x = expPos.x - 4'd1;
            if (keyReg == gamePkg::KeyDown && int'(expPos.y) < MapSize - 1)
                expPos.y = expPos.y + 4'd1;
            if (keyReg == gamePkg::KeyUp && expPos.y != 4'd0)
                expPos.y = expPos.y - 4'd1;
        end
        if (!expScreen.battle)
        begin
            expStatus  = {PlayerStart, BossStart};
            strikeCnt  = 0;
            playerDied = 1'b0;
            bossDied   = 1'b0;
        end
        else
        begin
            strike   = (strikeCnt == BossPeriod - 1);
            bossDied = 1'b0;
            if (press && keyReg == gamePkg::KeyAttack)
            begin
                hp       = int'(expStatus.bossHp) - int'(gamePkg::AttackDamage);
                bossDied = (hp <= 0);
                expStatus.bossHp = bossDied ? 8'd0 : 8'(hp);
            end
            // boss strike lands in the same edge as an attack
            hp         = int'(expStatus.playerHp) - int'(gamePkg::BossDamage);
            playerDied = strike && (hp <= 0);
            if (strike)
                expStatus.playerHp = playerDied ? 8'd0 : 8'(hp);
            strikeCnt = strike ? 0 : strikeCnt + 1;
        end
        expScreen = nextScreen;
        prevKey   = keyReg;
        keyReg    = keycode;
    endtask

    task automatic checkValue(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic runCycle(input logic [7:0] nextKey, input logic inReset);
        @(posedge Clk);
        if (!rstN)
            resetModel();
        else
            stepModel();
        #1;
        keycode = nextKey;
        rstN    = !inReset;
        // reset clears the DUT without waiting for an edge
        if (inReset)
            resetModel();
        #1;
        checkValue("screen", {13'd0, screen}, {13'd0, expScreen});
        checkValue("pos", {8'd0, pos}, {8'd0, expPos});
        checkValue("status", status, expStatus);
    endtask

    task automatic tap(input logic [7:0] code);
        runCycle(code, 1'b0);
        runCycle(8'h00, 1'b0);
    endtask

    task automatic pulseReset();
        repeat (3) runCycle(8'h00, 1'b1);
    endtask

    task automatic waitScreen(input gamePkg::ScreenSel target, input int limit);
        int n;
        n = 0;
        while (screen != target && n < limit)
        begin
            runCycle(8'h00, 1'b0);
            n++;
        end
        if (screen != target)
        begin
            $display("Timeout: screen %b not reached within %0d cycles", target, limit);
            $display("CHECKS FAILED");
            $fatal(1, "screen wait timed out");
        end
    endtask

    initial
    begin
        seedInit = $urandom(48);
        rstN     = 1'b0;
        keycode  = 8'h00;
        resetModel();
        pulseReset();
        // arrows do nothing on the intro screen
        tap(gamePkg::KeyRight);
        runCycle(8'h00, 1'b0);
        checkValue("intro pos", {8'd0, pos}, {8'd0, gamePkg::StartX, gamePkg::StartY});
        checkValue("full health", status, {PlayerStart, BossStart});
        // held space gives one move to the map
        repeat (4) runCycle(gamePkg::KeySpace, 1'b0);
        waitScreen(MapSel, 4);
        repeat (3) tap(gamePkg::KeyLeft);
        repeat (3) tap(gamePkg::KeyUp);
        checkValue("corner pos", {8'd0, pos}, 16'h0000);
        tap(gamePkg::KeyBattle);
        waitScreen(BattleSel, 4);
        tap(gamePkg::KeyEscape);
        waitScreen(MapSel, 4);
        // past the right edge, then back onto the door
        repeat (16) tap(gamePkg::KeyRight);
        checkValue("right edge", {12'd0, pos.x}, 16'(MapSize - 1));
        repeat (3) tap(gamePkg::KeyLeft);
        repeat (3) tap(gamePkg::KeyDown);
        waitScreen(BattleSel, 4);
        // five attacks finish the boss before its first strike
        repeat (5) tap(gamePkg::KeyAttack);
        waitScreen(IntroSel, 8);
        tap(gamePkg::KeySpace);
        tap(gamePkg::KeyBattle);
        waitScreen(BattleSel, 4);
        // idle fight, the boss wins
        waitScreen(IntroSel, 100);
        for (int n = 0; n < RandomCycles; n += hold)
        begin
            case ($urandom_range(0, 11))
                0:       key = gamePkg::KeySpace;
                1:       key = gamePkg::KeyEscape;
                2:       key = gamePkg::KeyBattle;
                3:       key = gamePkg::KeyAttack;
                4:       key = gamePkg::KeyRight;
                5:       key = gamePkg::KeyLeft;
                6:       key = gamePkg::KeyDown;
                7:       key = gamePkg::KeyUp;
                8, 9:    key = 8'h00;
                default: key = 8'($urandom_range(0, 255));
            endcase
            hold = int'($urandom_range(1, 4));
            // one more reset halfway through
            if (n < RandomCycles / 2 && n + hold >= RandomCycles / 2)
                pulseReset();
            repeat (hold) runCycle(key, 1'b0);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
src/gamePkg.sv
src/keyDecoder.sv
src/screenFsm.sv
src/mapWalker.sv
src/battleEngine.sv
src/gameTop.sv
verif/gameTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the game testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f flist.f --top-module gameTb -o gameSim \
    && ./obj_dir/gameSim > sim.log 2>&1

cat sim.log 2>/dev/null

# pass only when the log holds the pass line
grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
